// File: common/apb_if.sv
// APB interface with master and slave modports
`timescale 1ns/10ps

interface apb_if
    import soc_periph_pkg::*;
();

    apb_addr_t paddr;
    apb_data_t pwdata;
    logic      pwrite;
    logic      psel;
    logic      penable;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    // decoder side, drives the request
    modport master (
        output paddr, pwdata, pwrite, psel, penable,
        input  prdata, pready, pslverr
    );

    // peripheral side, drives the response
    modport slave (
        input  paddr, pwdata, pwrite, psel, penable,
        output prdata, pready, pslverr
    );

endinterface

// File: common/soc_periph_pkg.sv
// shared bus types, address map, register offsets, fc event positions and watchdog key
package soc_periph_pkg;

    // APB bus words
    typedef logic [31:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // fabric controller event word
    typedef logic [31:0] fc_events_t;

    // slave select field sits at address bits 13:12
    localparam int unsigned slave_sel_lsb = 12;

    localparam logic [1:0] slave_gpio = 2'd0;
    localparam logic [1:0] slave_wdt  = 2'd1;

    // GPIO register byte offsets, only bits 5:2 are decoded
    localparam logic [5:0] gpio_dir_off        = 6'h00;
    localparam logic [5:0] gpio_out_off        = 6'h04;
    localparam logic [5:0] gpio_in_off         = 6'h08;
    localparam logic [5:0] gpio_irq_en_off     = 6'h0C;
    localparam logic [5:0] gpio_irq_status_off = 6'h10;

    // watchdog register byte offsets
    localparam logic [5:0] wdt_ctrl_off  = 6'h00;
    localparam logic [5:0] wdt_load_off  = 6'h04;
    localparam logic [5:0] wdt_count_off = 6'h08;
    localparam logic [5:0] wdt_kick_off  = 6'h0C;

    // only this exact value written to the kick register reloads the counter
    localparam apb_data_t wdt_kick_key = 32'h5a5a_c3c3;

    // bit positions inside the fc event word
    localparam int unsigned fc_evt_ref_edge = 14;
    localparam int unsigned fc_evt_gpio     = 15;

endpackage

// File: gpio/apb_gpio.sv
// APB GPIO peripheral: direction, output, synchronized input and rising-edge interrupt registers
`timescale 1ns/10ps

module apb_gpio
    import soc_periph_pkg::*;
#(
    parameter int unsigned n_gpio = 32
) (
    input  logic              clk_i,
    input  logic              rst_n_i,

    apb_if.slave              bus,

    input  logic [n_gpio-1:0] gpio_in_i,
    output logic [n_gpio-1:0] gpio_out_o,
    output logic [n_gpio-1:0] gpio_dir_o,
    output logic              gpio_event_o
);

    logic [n_gpio-1:0] gpio_dir_q;
    logic [n_gpio-1:0] gpio_out_q;
    logic [n_gpio-1:0] irq_en_q;
    logic [n_gpio-1:0] irq_status_q;

    logic [n_gpio-1:0] sync1_q;
    logic [n_gpio-1:0] sync2_q;
    logic [n_gpio-1:0] prev_q;
    logic [n_gpio-1:0] rise;

    logic [5:0]        reg_off;
    logic              wr_en;
    logic              rd_en;
    logic              status_clr;
    apb_data_t         rdata;

    assign reg_off    = {bus.paddr[5:2], 2'b00};
    assign wr_en      = bus.psel && bus.penable && bus.pwrite;
    assign rd_en      = bus.psel && bus.penable && !bus.pwrite;
    assign status_clr = rd_en && (reg_off == gpio_irq_status_off);

    //////////////////////////////////////////////////
    // input synchronizer and edge detect
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    assign rise = sync2_q & ~prev_q;

    //////////////////////////////////////////////////
    // configuration and status registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            gpio_dir_q <= '0;
            gpio_out_q <= '0;
            irq_en_q   <= '0;
        end else if (wr_en) begin
            case (reg_off)
                gpio_dir_off:    gpio_dir_q <= bus.pwdata[n_gpio-1:0];
                gpio_out_off:    gpio_out_q <= bus.pwdata[n_gpio-1:0];
                gpio_irq_en_off: irq_en_q   <= bus.pwdata[n_gpio-1:0];
                default: ;
            endcase
        end
    end

    // an edge in the clearing cycle still gets recorded
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            irq_status_q <= '0;
        end else begin
            irq_status_q <= (status_clr ? '0 : irq_status_q) | (rise & irq_en_q);
        end
    end

    // read mux, unused offsets read zero
    always_comb begin
        rdata = '0;
        case (reg_off)
            gpio_dir_off:        rdata[n_gpio-1:0] = gpio_dir_q;
            gpio_out_off:        rdata[n_gpio-1:0] = gpio_out_q;
            gpio_in_off:         rdata[n_gpio-1:0] = sync2_q;
            gpio_irq_en_off:     rdata[n_gpio-1:0] = irq_en_q;
            gpio_irq_status_off: rdata[n_gpio-1:0] = irq_status_q;
            default: ;
        endcase
    end

    assign bus.prdata  = rdata;
    assign bus.pready  = 1'b1;
    assign bus.pslverr = 1'b0;

    assign gpio_dir_o   = gpio_dir_q;
    assign gpio_out_o   = gpio_out_q;
    assign gpio_event_o = |irq_status_q;

endmodule

// File: soc_periph_lite.f
+incdir+test
common/soc_periph_pkg.sv
common/apb_if.sv
verilog/periph_bus_decoder.sv
gpio/apb_gpio.sv
wdt/apb_wdt.sv
verilog/fc_event_map.sv
verilog/soc_periph_lite.sv
test/tb_soc_periph_lite.sv

// File: test/tb_apb_tasks.svh
// APB write and read tasks plus the value compare used by the testbench
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// compare one value, report and count a mismatch against the running test
task automatic check_value(input string name, input string what,
                           input apb_data_t exp, input apb_data_t act);
    if (act !== exp) begin
        $display("CHECK FAILED %s %s expected %h actual %h", name, what, exp, act);
        test_errs++;
    end
endtask

// pready must be high in every access cycle, no wait states exist
task automatic ready_check();
    if (pready_o !== 1'b1) begin
        $display("%s: pready was not high in the access cycle", cur_name);
        test_errs++;
    end
endtask

// entered on a falling edge, leaves on the falling edge after the access cycle
task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    paddr_i   = addr;
    pwdata_i  = data;
    pwrite_i  = 1'b1;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(negedge clk_i);
    penable_i = 1'b1;
    // sample mid low phase, well away from both edges
    #(clk_period / 4);
    err = pslverr_o;
    ready_check();
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
endtask

task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    paddr_i   = addr;
    pwrite_i  = 1'b0;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(negedge clk_i);
    penable_i = 1'b1;
    #(clk_period / 4);
    data = prdata_o;
    err  = pslverr_o;
    ready_check();
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
endtask

`endif

// File: test/tb_soc_periph_lite.sv
// testbench top: clock, reset, stimulus table, step loop, run limit and summary
`timescale 1ns/10ps

module tb_soc_periph_lite
    import soc_periph_pkg::*;
();

    localparam int unsigned n_gpio          = 32;
    localparam int unsigned clk_period      = 100;
    localparam int unsigned reset_cycles    = 16;
    localparam int unsigned cycles_per_step = 100;

    // step operations
    localparam int op_write = 0;
    localparam int op_read  = 1;
    localparam int op_gpio  = 2;
    localparam int op_slow  = 3;
    localparam int op_wait  = 4;
    localparam int op_check = 5;

    // output selected by a check step, held in the address column
    localparam int chk_dir       = 0;
    localparam int chk_out       = 1;
    localparam int chk_wdt       = 2;
    localparam int chk_gpio_evt  = 3;
    localparam int chk_ref_count = 4;

    logic              clk_i;
    logic              rst_n_i;
    apb_addr_t         paddr_i;
    apb_data_t         pwdata_i;
    logic              pwrite_i;
    logic              psel_i;
    logic              penable_i;
    apb_data_t         prdata_o;
    logic              pready_o;
    logic              pslverr_o;
    logic              slow_clk_i;
    logic [n_gpio-1:0] gpio_in_i;
    logic [n_gpio-1:0] gpio_out_o;
    logic [n_gpio-1:0] gpio_dir_o;
    fc_events_t        fc_events_o;
    logic              wdt_reset_o;

    // stimulus table, one entry per step
    string     step_name[$];
    int        step_op[$];
    apb_addr_t step_addr[$];
    apb_data_t step_data[$];
    apb_data_t step_exp[$];

    string       cur_name;
    int unsigned test_errs;
    int unsigned pass_cnt;
    int unsigned fail_cnt;
    int unsigned ref_pulses;
    logic        stray_seen;

    `include "tb_apb_tasks.svh"

    soc_periph_lite #(
        .n_gpio ( n_gpio )
    ) u_soc_periph_lite (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .paddr_i     ( paddr_i     ),
        .pwdata_i    ( pwdata_i    ),
        .pwrite_i    ( pwrite_i    ),
        .psel_i      ( psel_i      ),
        .penable_i   ( penable_i   ),
        .prdata_o    ( prdata_o    ),
        .pready_o    ( pready_o    ),
        .pslverr_o   ( pslverr_o   ),
        .slow_clk_i  ( slow_clk_i  ),
        .gpio_in_i   ( gpio_in_i   ),
        .gpio_out_o  ( gpio_out_o  ),
        .gpio_dir_o  ( gpio_dir_o  ),
        .fc_events_o ( fc_events_o ),
        .wdt_reset_o ( wdt_reset_o )
    );

    always #(clk_period / 2) clk_i = ~clk_i;

    //////////////////////////////////////////////////
    // fc event monitor, sampled where outputs are stable
    //////////////////////////////////////////////////

    always @(negedge clk_i) begin
        // mid low phase, clear of the step loop and of both clock edges
        #(clk_period / 4);
        if (rst_n_i) begin
            if (fc_events_o[fc_evt_ref_edge]) begin
                ref_pulses++;
            end
            // bits 14 and 15 are the only live ones
            if (((fc_events_o & ~32'h0000_c000) != '0) && !stray_seen) begin
                $display("%s: fc event bits other than 14 and 15 went high (%h)",
                         cur_name, fc_events_o);
                stray_seen = 1'b1;
                test_errs++;
            end
        end
    end

    task automatic add_step(input string name, input int op, input apb_addr_t addr,
                            input apb_data_t data, input apb_data_t exp);
        step_name.push_back(name);
        step_op.push_back(op);
        step_addr.push_back(addr);
        step_data.push_back(data);
        step_exp.push_back(exp);
    endtask

    task automatic run_step(input int idx);
        apb_data_t  rdata;
        apb_data_t  act;
        logic       err;
        logic       exp_err;
        logic [1:0] sel;
        sel     = step_addr[idx][slave_sel_lsb +: 2];
        exp_err = (sel != slave_gpio) && (sel != slave_wdt);
        case (step_op[idx])
            op_write: begin
                apb_write(step_addr[idx], step_data[idx], err);
                check_value(step_name[idx], "pslverr", {31'b0, exp_err}, {31'b0, err});
            end
            op_read: begin
                apb_read(step_addr[idx], rdata, err);
                check_value(step_name[idx], "prdata", step_exp[idx], rdata);
                check_value(step_name[idx], "pslverr", {31'b0, exp_err}, {31'b0, err});
            end
            op_gpio: gpio_in_i = step_data[idx][n_gpio-1:0];
            op_slow: begin
                slow_clk_i = ~slow_clk_i;
                repeat (step_data[idx]) @(negedge clk_i);
            end
            op_wait: repeat (step_data[idx]) @(negedge clk_i);
            default: begin
                case (step_addr[idx])
                    chk_dir:       act = apb_data_t'(gpio_dir_o);
                    chk_out:       act = apb_data_t'(gpio_out_o);
                    chk_wdt:       act = {31'b0, wdt_reset_o};
                    chk_gpio_evt:  act = {31'b0, fc_events_o[fc_evt_gpio]};
                    chk_ref_count: act = ref_pulses;
                    default:       act = '1;
                endcase
                check_value(step_name[idx], "output", step_exp[idx], act);
            end
        endcase
    endtask

    // watchdog on the whole run
    initial begin
        #1;
        repeat (step_name.size() * cycles_per_step) @(posedge clk_i);
        $display("run limit of %0d cycles reached, test did not finish",
                 step_name.size() * cycles_per_step);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int unsigned seed;
        apb_data_t   gpio_mask;
        apb_data_t   dir_val;
        apb_data_t   out_val;
        apb_data_t   pat;
        int unsigned pin_en;
        int unsigned pin_dis;
        logic        last_of_test;
        clk_i      = 1'b0;
        rst_n_i    = 1'b0;
        paddr_i    = '0;
        pwdata_i   = '0;
        pwrite_i   = 1'b0;
        psel_i     = 1'b0;
        penable_i  = 1'b0;
        slow_clk_i = 1'b0;
        gpio_in_i  = '0;
        test_errs  = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        ref_pulses = 0;
        stray_seen = 1'b0;
        cur_name   = "reset";
        seed       = 32'h7eb5a0de;
        void'($urandom(seed));

        gpio_mask = 32'hffff_ffff >> (32 - n_gpio);
        dir_val   = $urandom;
        out_val   = $urandom;
        pat       = $urandom;
        pin_en    = $urandom % n_gpio;
        pin_dis   = (pin_en + 1) % n_gpio;

        // gpio register readback
        add_step("gpio_regs", op_write, gpio_dir_off, dir_val, 0);
        add_step("gpio_regs", op_write, gpio_out_off, out_val, 0);
        add_step("gpio_regs", op_read, gpio_dir_off, 0, dir_val & gpio_mask);
        add_step("gpio_regs", op_read, gpio_out_off, 0, out_val & gpio_mask);
        add_step("gpio_regs", op_check, chk_dir, 0, dir_val & gpio_mask);
        add_step("gpio_regs", op_check, chk_out, 0, out_val & gpio_mask);

        // input sync, then one enabled and one disabled rising pin
        add_step("gpio_irq", op_gpio, 0, pat, 0);
        add_step("gpio_irq", op_wait, 0, 4, 0);
        add_step("gpio_irq", op_read, gpio_in_off, 0, pat & gpio_mask);
        add_step("gpio_irq", op_gpio, 0, 0, 0);
        add_step("gpio_irq", op_wait, 0, 4, 0);
        add_step("gpio_irq", op_write, gpio_irq_en_off, 32'd1 << pin_en, 0);
        add_step("gpio_irq", op_gpio, 0, (32'd1 << pin_en) | (32'd1 << pin_dis), 0);
        add_step("gpio_irq", op_wait, 0, 5, 0);
        add_step("gpio_irq", op_check, chk_gpio_evt, 0, 1);
        add_step("gpio_irq", op_read, gpio_irq_status_off, 0, 32'd1 << pin_en);
        add_step("gpio_irq", op_wait, 0, 2, 0);
        add_step("gpio_irq", op_check, chk_gpio_evt, 0, 0);
        add_step("gpio_irq", op_read, gpio_irq_status_off, 0, 0);

        // select codes 2 and 3 hit no slave
        add_step("unmapped", op_read, 32'h0000_2000, 0, 0);
        add_step("unmapped", op_write, 32'h0000_3000, ~dir_val, 0);
        add_step("unmapped", op_read, gpio_dir_off, 0, dir_val & gpio_mask);
        add_step("unmapped", op_read, gpio_out_off, 0, out_val & gpio_mask);
        add_step("unmapped", op_check, chk_dir, 0, dir_val & gpio_mask);

        // count register: reload to 20 at the kick, then three clocks down
        add_step("wdt", op_write, 32'h1000 | wdt_load_off, 20, 0);
        add_step("wdt", op_write, 32'h1000 | wdt_ctrl_off, 1, 0);
        add_step("wdt", op_wait, 0, 15, 0);
        add_step("wdt", op_check, chk_wdt, 0, 0);
        add_step("wdt", op_wait, 0, 10, 0);
        add_step("wdt", op_check, chk_wdt, 0, 1);
        add_step("wdt", op_write, 32'h1000 | wdt_kick_off, ~wdt_kick_key, 0);
        // a reload would have dropped the reset output by now
        add_step("wdt", op_wait, 0, 2, 0);
        add_step("wdt", op_check, chk_wdt, 0, 1);
        add_step("wdt", op_write, 32'h1000 | wdt_kick_off, wdt_kick_key, 0);
        add_step("wdt", op_wait, 0, 2, 0);
        add_step("wdt", op_check, chk_wdt, 0, 0);
        add_step("wdt", op_read, 32'h1000 | wdt_count_off, 0, 17);
        add_step("wdt", op_write, 32'h1000 | wdt_ctrl_off, 0, 0);
        add_step("wdt", op_wait, 0, 30, 0);
        add_step("wdt", op_check, chk_wdt, 0, 0);

        // every slow clock edge gives exactly one pulse
        add_step("ref_events", op_check, chk_ref_count, 0, 0);
        for (int k = 0; k < 6; k++) begin
            add_step("ref_events", op_slow, 0, 20, 0);
        end
        add_step("ref_events", op_check, chk_ref_count, 0, 6);

        repeat (reset_cycles) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        for (int i = 0; i < step_name.size(); i++) begin
            cur_name = step_name[i];
            run_step(i);
            last_of_test = 1'b1;
            if (i + 1 < step_name.size()) begin
                last_of_test = (step_name[i + 1] != step_name[i]);
            end
            if (last_of_test) begin
                if (test_errs == 0) begin
                    $display("test %s: ok", step_name[i]);
                    pass_cnt++;
                end else begin
                    $display("test %s: %0d errors", step_name[i], test_errs);
                    fail_cnt++;
                end
                test_errs = 0;
            end
        end

        $display("tests passed %0d, tests failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/fc_event_map.sv
// reference clock synchronizer, edge detector and registered fc event word
`timescale 1ns/10ps

module fc_event_map
    import soc_periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       slow_clk_i,
    input  logic       gpio_event_i,
    output fc_events_t fc_events_o
);

    logic       ref_sync1_q;
    logic       ref_sync2_q;
    logic       ref_prev_q;
    logic       ref_edge;
    fc_events_t evt_d;
    fc_events_t evt_q;

    // two stage sync, then one flop for the edge compare
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ref_sync1_q <= 1'b0;
            ref_sync2_q <= 1'b0;
            ref_prev_q  <= 1'b0;
        end else begin
            ref_sync1_q <= slow_clk_i;
            ref_sync2_q <= ref_sync1_q;
            ref_prev_q  <= ref_sync2_q;
        end
    end

    // rise and fall both count as a reference event
    assign ref_edge = ref_sync2_q ^ ref_prev_q;

    always_comb begin
        evt_d                  = '0;
        evt_d[fc_evt_ref_edge] = ref_edge;
        evt_d[fc_evt_gpio]     = gpio_event_i;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            evt_q <= '0;
        end else begin
            evt_q <= evt_d;
        end
    end

    assign fc_events_o = evt_q;

endmodule

// File: verilog/periph_bus_decoder.sv
// APB address decoder routing transfers to the GPIO and watchdog slaves with error response
`timescale 1ns/10ps

module periph_bus_decoder
    import soc_periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,

    // external APB port
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    input  logic      pwrite_i,
    input  logic      psel_i,
    input  logic      penable_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,

    // slave side
    apb_if.master     gpio_bus,
    apb_if.master     wdt_bus
);

    logic [1:0] slave_sel;
    logic       setup_q;
    logic       err_access;

    assign slave_sel = paddr_i[slave_sel_lsb +: 2];

    // request is broadcast, only psel is steered
    assign gpio_bus.paddr   = paddr_i;
    assign gpio_bus.pwdata  = pwdata_i;
    assign gpio_bus.pwrite  = pwrite_i;
    assign gpio_bus.penable = penable_i;
    assign gpio_bus.psel    = psel_i && (slave_sel == slave_gpio);

    assign wdt_bus.paddr    = paddr_i;
    assign wdt_bus.pwdata   = pwdata_i;
    assign wdt_bus.pwrite   = pwrite_i;
    assign wdt_bus.penable  = penable_i;
    assign wdt_bus.psel     = psel_i && (slave_sel == slave_wdt);

    // remembers that the previous cycle was a setup phase
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= psel_i && !penable_i;
        end
    end

    // unmapped access phase, flagged only after a proper setup phase
    assign err_access = psel_i && penable_i && setup_q;

    // response mux, same cycle
    always_comb begin
        case (slave_sel)
            slave_gpio: begin
                prdata_o  = gpio_bus.prdata;
                pready_o  = gpio_bus.pready;
                pslverr_o = gpio_bus.pslverr;
            end
            slave_wdt: begin
                prdata_o  = wdt_bus.prdata;
                pready_o  = wdt_bus.pready;
                pslverr_o = wdt_bus.pslverr;
            end
            default: begin
                prdata_o  = '0;
                pready_o  = 1'b1;
                pslverr_o = err_access;
            end
        endcase
    end

endmodule

// File: verilog/soc_periph_lite.sv
// peripheral subsystem top: APB decoder, GPIO, watchdog and fc event mapping
`timescale 1ns/10ps

module soc_periph_lite
    import soc_periph_pkg::*;
#(
    parameter int unsigned n_gpio = 32
) (
    input  logic              clk_i,
    input  logic              rst_n_i,

    // APB slave port
    input  apb_addr_t         paddr_i,
    input  apb_data_t         pwdata_i,
    input  logic              pwrite_i,
    input  logic              psel_i,
    input  logic              penable_i,
    output apb_data_t         prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,

    input  logic              slow_clk_i,

    input  logic [n_gpio-1:0] gpio_in_i,
    output logic [n_gpio-1:0] gpio_out_o,
    output logic [n_gpio-1:0] gpio_dir_o,

    output fc_events_t        fc_events_o,
    output logic              wdt_reset_o
);

    logic gpio_event;

    apb_if gpio_bus ();
    apb_if wdt_bus ();

    //////////////////////////////////////////////////
    // peripheral bus
    //////////////////////////////////////////////////

    periph_bus_decoder u_bus (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .pwrite_i  ( pwrite_i  ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o ),
        .gpio_bus  ( gpio_bus  ),
        .wdt_bus   ( wdt_bus   )
    );

    //////////////////////////////////////////////////
    // peripherals
    //////////////////////////////////////////////////

    apb_gpio #(
        .n_gpio ( n_gpio )
    ) u_gpio (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .bus          ( gpio_bus   ),
        .gpio_in_i    ( gpio_in_i  ),
        .gpio_out_o   ( gpio_out_o ),
        .gpio_dir_o   ( gpio_dir_o ),
        .gpio_event_o ( gpio_event )
    );

    apb_wdt u_wdt (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .bus         ( wdt_bus     ),
        .wdt_reset_o ( wdt_reset_o )
    );

    //////////////////////////////////////////////////
    // fc event word
    //////////////////////////////////////////////////

    fc_event_map u_evt (
        .clk_i        ( clk_i       ),
        .rst_n_i      ( rst_n_i     ),
        .slow_clk_i   ( slow_clk_i  ),
        .gpio_event_i ( gpio_event  ),
        .fc_events_o  ( fc_events_o )
    );

endmodule

// File: wdt/apb_wdt.sv
// APB watchdog: control and load registers, down-counter, kick check and reset output
`timescale 1ns/10ps

module apb_wdt
    import soc_periph_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,

    apb_if.slave  bus,

    output logic  wdt_reset_o
);

    logic      enable_q;
    apb_data_t load_q;
    apb_data_t count_q;
    logic      reset_q;

    logic [5:0] reg_off;
    logic       wr_en;
    logic       kick;
    logic       count_zero;
    apb_data_t  rdata;

    assign reg_off    = {bus.paddr[5:2], 2'b00};
    assign wr_en      = bus.psel && bus.penable && bus.pwrite;
    assign count_zero = (count_q == '0);

    // wrong key values are silently dropped
    assign kick = wr_en && (reg_off == wdt_kick_off) && (bus.pwdata == wdt_kick_key);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            enable_q <= 1'b0;
            load_q   <= '0;
        end else if (wr_en) begin
            case (reg_off)
                wdt_ctrl_off: enable_q <= bus.pwdata[0];
                wdt_load_off: load_q   <= bus.pwdata;
                default: ;
            endcase
        end
    end

    // kick has priority, then preload while stopped, then count down
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (kick) begin
            count_q <= load_q;
        end else if (wr_en && (reg_off == wdt_load_off) && !enable_q) begin
            count_q <= bus.pwdata;
        end else if (enable_q && !count_zero) begin
            count_q <= count_q - 1'b1;
        end
    end

    // expiry flag follows the counter by one clock
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            reset_q <= 1'b0;
        end else begin
            reset_q <= enable_q && count_zero;
        end
    end

    always_comb begin
        rdata = '0;
        case (reg_off)
            wdt_ctrl_off:  rdata[0] = enable_q;
            wdt_load_off:  rdata    = load_q;
            wdt_count_off: rdata    = count_q;
            default: ;
        endcase
    end

    assign bus.prdata  = rdata;
    assign bus.pready  = 1'b1;
    assign bus.pslverr = 1'b0;

    assign wdt_reset_o = reset_q;

endmodule
